// ==== rv_defines.svh ====
//////////////////////////////
// RV32I base encodings only; no M, FENCE or CSR opcodes
//////////////////////////////
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// pc after reset
`define RV_RESET_PC 32'h0000_0000

// architectural registers, x0 included
`define RV_NUM_REGS 32

// major opcodes, insn[6:0]
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_SYSTEM 7'b1110011

// funct7 selecting sub and sra/srai
`define RV_F7_ALT 7'b0100000

`endif

// ==== rv_pkg.sv ====
//////////////////////////////
// types only, widths fixed by RV32I
//////////////////////////////
package rv_pkg;

  // register value, pc or instruction word
  typedef logic [31:0] word_t;

  // register index, x0..x31
  typedef logic [4:0] reg_idx_t;

  // instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // fetch sequencer, one instruction in flight at a time
  typedef enum logic [1:0] {
    // arm the bus request
    F_REQ,
    // cyc/stb high until the slave acks
    F_WAIT,
    // single cycle of execute, write-back and retire
    F_EXEC,
    // entered after ecall, left only by reset
    F_HALT
  } fetch_state_t;

  // decoded operation class
  typedef enum logic [3:0] {
    OC_LUI,
    OC_AUIPC,
    // alu with I-immediate as second operand
    OC_ALU_IMM,
    // alu with rs2 as second operand
    OC_ALU_REG,
    OC_BRANCH,
    OC_JAL,
    OC_JALR,
    // ecall, nothing else in SYSTEM is accepted
    OC_SYSTEM,
    // retires as a no-op
    OC_ILLEGAL
  } op_class_t;

endpackage

// ==== rv_fetch.sv ====
//////////////////////////////
// one fetch outstanding; byte select is implicitly all ones
//////////////////////////////
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_fetch (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t pc_next,
  input  logic          halt_req,
  input  logic          wb_ack,
  input  rv_pkg::word_t wb_dat_i,
  output logic          wb_cyc,
  output logic          wb_stb,
  output logic          wb_we,
  output rv_pkg::word_t wb_adr,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t insn,
  output logic          exec_valid,
  output logic          halt
);
  import rv_pkg::*;

  fetch_state_t state;
  logic         req;

  // sequencer, bus request and pc
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= F_REQ;
      req   <= 1'b0;
      pc    <= `RV_RESET_PC;
    end else begin
      case (state)
        F_REQ: begin
          // cyc/stb go high next cycle
          req   <= 1'b1;
          state <= F_WAIT;
        end
        F_WAIT: begin
          // slave may stretch this for any number of cycles
          if (wb_ack) begin
            req   <= 1'b0;
            state <= F_EXEC;
          end
        end
        F_EXEC: begin
          pc <= pc_next;
          if (halt_req) begin
            state <= F_HALT;
          end else begin
            state <= F_REQ;
          end
        end
        default: begin
          // sticky until reset
          state <= F_HALT;
        end
      endcase
    end
  end

  // instruction word taken on the ack edge
  always_ff @(posedge clk) begin
    if (state == F_WAIT && wb_ack) begin
      insn <= wb_dat_i;
    end
  end

  // instruction side is read only
  assign wb_we  = 1'b0;
  assign wb_cyc = req;
  assign wb_stb = req;

  // pc only moves in F_EXEC, so the address is stable while stb is high
  assign wb_adr = pc;

  assign exec_valid = (state == F_EXEC);
  assign halt       = (state == F_HALT);

endmodule

// ==== rv_decode.sv ====
//////////////////////////////
// FENCE, EBREAK and CSR words decode as illegal
//////////////////////////////
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decode (
  input  rv_pkg::word_t     insn,
  output rv_pkg::op_class_t op_class,
  output rv_pkg::funct3_t   funct3,
  output logic              alt,
  output rv_pkg::reg_idx_t  rs1,
  output rv_pkg::reg_idx_t  rs2,
  output rv_pkg::reg_idx_t  rd,
  output rv_pkg::word_t     imm
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  // field split, R-type layout
  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];
  assign alt    = (funct7 == `RV_F7_ALT);

  // sign-extended immediates by format
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'h000};

  always_comb begin
    op_class = OC_ILLEGAL;
    imm      = '0;
    case (opcode)
      `RV_OP_LUI: begin
        op_class = OC_LUI;
        imm      = imm_u;
      end
      `RV_OP_AUIPC: begin
        op_class = OC_AUIPC;
        imm      = imm_u;
      end
      `RV_OP_JAL: begin
        op_class = OC_JAL;
        imm      = imm_j;
      end
      `RV_OP_JALR: begin
        imm = imm_i;
        if (funct3 == 3'b000) begin
          op_class = OC_JALR;
        end
      end
      `RV_OP_BRANCH: begin
        imm = imm_b;
        // funct3 010 and 011 are unassigned
        if (funct3[2:1] != 2'b01) begin
          op_class = OC_BRANCH;
        end
      end
      `RV_OP_IMM: begin
        imm = imm_i;
        // shifts carry funct7 in the upper immediate bits
        if (funct3 == 3'b001) begin
          if (funct7 == 7'd0) begin
            op_class = OC_ALU_IMM;
          end
        end else if (funct3 == 3'b101) begin
          if (funct7 == 7'd0 || alt) begin
            op_class = OC_ALU_IMM;
          end
        end else begin
          op_class = OC_ALU_IMM;
        end
      end
      `RV_OP_REG: begin
        // alt only valid for sub and sra
        if (funct7 == 7'd0 || (alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          op_class = OC_ALU_REG;
        end
      end
      `RV_OP_SYSTEM: begin
        // ecall is the all-zero word above the opcode
        if (insn[31:7] == 25'd0) begin
          op_class = OC_SYSTEM;
        end
      end
      default: begin
        op_class = OC_ILLEGAL;
      end
    endcase
  end

endmodule

// ==== rv_regfile.sv ====
//////////////////////////////
// reads are combinational, write lands at the clock edge
//////////////////////////////
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  // x0 has no storage
  word_t regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== rv_execute.sv ====
//////////////////////////////
// purely combinational, results valid while exec_valid is high
//////////////////////////////
`timescale 1ns/1ps

module rv_execute (
  input  logic              exec_valid,
  input  rv_pkg::word_t     pc,
  input  rv_pkg::op_class_t op_class,
  input  rv_pkg::funct3_t   funct3,
  input  logic              alt,
  input  rv_pkg::reg_idx_t  rd,
  input  rv_pkg::word_t     imm,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  output rv_pkg::word_t     pc_next,
  output logic              halt_req,
  output logic              rd_we,
  output rv_pkg::word_t     rd_data,
  output logic              retire_valid,
  output rv_pkg::word_t     retire_pc,
  output rv_pkg::reg_idx_t  retire_rd,
  output logic              retire_we
);
  import rv_pkg::*;

  word_t      op_b;
  logic [4:0] shamt;
  word_t      alu_out;
  word_t      pc_plus4;
  word_t      pc_imm;
  logic       take_branch;
  logic       writes_rd;

  // second operand, shamt is its low five bits either way
  assign op_b     = (op_class == OC_ALU_REG) ? rs2_data : imm;
  assign shamt    = op_b[4:0];
  assign pc_plus4 = pc + 32'd4;
  // shared by auipc, branch and jal
  assign pc_imm   = pc + imm;

  always_comb begin
    case (funct3)
      3'b000: begin
        // addi ignores funct7, so alt only means sub for register ops
        if (op_class == OC_ALU_REG && alt) begin
          alu_out = rs1_data - op_b;
        end else begin
          alu_out = rs1_data + op_b;
        end
      end
      3'b001: alu_out = rs1_data << shamt;
      3'b010: alu_out = word_t'({31'd0, $signed(rs1_data) < $signed(op_b)});
      3'b011: alu_out = word_t'({31'd0, rs1_data < op_b});
      3'b100: alu_out = rs1_data ^ op_b;
      3'b101: begin
        if (alt) begin
          alu_out = word_t'($signed(rs1_data) >>> shamt);
        end else begin
          alu_out = rs1_data >> shamt;
        end
      end
      3'b110: alu_out = rs1_data | op_b;
      default: alu_out = rs1_data & op_b;
    endcase
  end

  // branch condition by funct3
  always_comb begin
    case (funct3)
      3'b000: take_branch = (rs1_data == rs2_data);
      3'b001: take_branch = (rs1_data != rs2_data);
      3'b100: take_branch = ($signed(rs1_data) < $signed(rs2_data));
      3'b101: take_branch = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110: take_branch = (rs1_data < rs2_data);
      3'b111: take_branch = (rs1_data >= rs2_data);
      default: take_branch = 1'b0;
    endcase
  end

  // next pc and write-back value
  always_comb begin
    pc_next   = pc_plus4;
    rd_data   = '0;
    writes_rd = 1'b0;
    halt_req  = 1'b0;
    case (op_class)
      OC_LUI: begin
        rd_data   = imm;
        writes_rd = 1'b1;
      end
      OC_AUIPC: begin
        rd_data   = pc_imm;
        writes_rd = 1'b1;
      end
      OC_ALU_IMM, OC_ALU_REG: begin
        rd_data   = alu_out;
        writes_rd = 1'b1;
      end
      OC_BRANCH: begin
        if (take_branch) begin
          pc_next = pc_imm;
        end
      end
      OC_JAL: begin
        rd_data   = pc_plus4;
        writes_rd = 1'b1;
        pc_next   = pc_imm;
      end
      OC_JALR: begin
        rd_data   = pc_plus4;
        writes_rd = 1'b1;
        pc_next   = (rs1_data + imm) & ~32'd1;
      end
      OC_SYSTEM: begin
        halt_req = 1'b1;
      end
      default: begin
        // illegal, falls through to pc+4 with no write
        writes_rd = 1'b0;
      end
    endcase
  end

  assign rd_we = exec_valid && writes_rd && (rd != 5'd0);

  // commit trace
  assign retire_valid = exec_valid;
  assign retire_pc    = pc;
  assign retire_rd    = rd;
  assign retire_we    = rd_we;

endmodule

// ==== rv_core.sv ====
//////////////////////////////
// instruction fetch only, no data bus
//////////////////////////////
`timescale 1ns/1ps

module rv_core (
  input  logic             clk,
  input  logic             rst,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output rv_pkg::word_t    wb_adr,
  input  logic             wb_ack,
  input  rv_pkg::word_t    wb_dat_i,
  output logic             halt,
  output logic             retire_valid,
  output rv_pkg::word_t    retire_pc,
  output rv_pkg::reg_idx_t retire_rd,
  output logic             retire_we,
  output rv_pkg::word_t    retire_data
);
  import rv_pkg::*;

  word_t     pc;
  word_t     pc_next;
  word_t     insn;
  logic      exec_valid;
  logic      halt_req;
  op_class_t op_class;
  funct3_t   funct3;
  logic      alt;
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  reg_idx_t  rd;
  word_t     imm;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      rd_we;

  rv_fetch fetch_i (
    .clk        (clk),
    .rst        (rst),
    .pc_next    (pc_next),
    .halt_req   (halt_req),
    .wb_ack     (wb_ack),
    .wb_dat_i   (wb_dat_i),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .pc         (pc),
    .insn       (insn),
    .exec_valid (exec_valid),
    .halt       (halt)
  );

  rv_decode decode_i (
    .insn     (insn),
    .op_class (op_class),
    .funct3   (funct3),
    .alt      (alt),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .imm      (imm)
  );

  // write-back value doubles as the trace data
  rv_regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .we       (rd_we),
    .rd       (rd),
    .rd_data  (retire_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute execute_i (
    .exec_valid   (exec_valid),
    .pc           (pc),
    .op_class     (op_class),
    .funct3       (funct3),
    .alt          (alt),
    .rd           (rd),
    .imm          (imm),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .pc_next      (pc_next),
    .halt_req     (halt_req),
    .rd_we        (rd_we),
    .rd_data      (retire_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_we    (retire_we)
  );

endmodule

// ==== tb_rv_program.svh ====
//////////////////////////////
// rows in retire order; skipped words are never fetched
//////////////////////////////
`ifndef TB_RV_PROGRAM_SVH
`define TB_RV_PROGRAM_SVH

  // columns: address, instruction, retire_we, retire_rd, retire_data
  // rd and data are compared only on rows with retire_we set
  task automatic load_program();
    // lui, auipc and addi constants
    add_row(32'h0000_0000, 32'h1234_50b7, 1'b1, 5'd1,  32'h1234_5000);
    add_row(32'h0000_0004, 32'h0000_1117, 1'b1, 5'd2,  32'h0000_1004);
    add_row(32'h0000_0008, 32'hffb0_0193, 1'b1, 5'd3,  32'hffff_fffb);
    add_row(32'h0000_000c, 32'h6780_8213, 1'b1, 5'd4,  32'h1234_5678);
    // sub, sra, srl, sltu, slt, xor, or, and, sll, add
    add_row(32'h0000_0010, 32'h4032_02b3, 1'b1, 5'd5,  32'h1234_567d);
    add_row(32'h0000_0014, 32'h4021_d333, 1'b1, 5'd6,  32'hffff_ffff);
    add_row(32'h0000_0018, 32'h0021_d3b3, 1'b1, 5'd7,  32'h0fff_ffff);
    add_row(32'h0000_001c, 32'h0032_3433, 1'b1, 5'd8,  32'h0000_0001);
    add_row(32'h0000_0020, 32'h0032_24b3, 1'b1, 5'd9,  32'h0000_0000);
    add_row(32'h0000_0024, 32'h0012_4533, 1'b1, 5'd10, 32'h0000_0678);
    add_row(32'h0000_0028, 32'h0025_65b3, 1'b1, 5'd11, 32'h0000_167c);
    add_row(32'h0000_002c, 32'h0045_f633, 1'b1, 5'd12, 32'h0000_1678);
    add_row(32'h0000_0030, 32'h0025_16b3, 1'b1, 5'd13, 32'h0000_6780);
    add_row(32'h0000_0034, 32'h0030_8733, 1'b1, 5'd14, 32'h1234_4ffb);
    // addi x0 is dropped, then x0 read back through add
    add_row(32'h0000_0038, 32'h0012_0013, 1'b0, 5'd0,  32'h0000_0000);
    add_row(32'h0000_003c, 32'h0050_07b3, 1'b1, 5'd15, 32'h1234_567d);
    // beq not taken, bne taken to 0x50
    add_row(32'h0000_0040, 32'h0040_8463, 1'b0, 5'd0,  32'h0000_0000);
    add_row(32'h0000_0044, 32'h0040_9663, 1'b0, 5'd0,  32'h0000_0000);
    // jal to 0x60, jalr to (0x54 + 0x11) with bit 0 cleared
    add_row(32'h0000_0050, 32'h0100_086f, 1'b1, 5'd16, 32'h0000_0054);
    add_row(32'h0000_0060, 32'h0118_08e7, 1'b1, 5'd17, 32'h0000_0064);
    // mul and fence are illegal, x18 must stay zero
    add_row(32'h0000_0064, 32'h0232_0933, 1'b0, 5'd0,  32'h0000_0000);
    add_row(32'h0000_0068, 32'h0ff0_000f, 1'b0, 5'd0,  32'h0000_0000);
    add_row(32'h0000_006c, 32'h0049_09b3, 1'b1, 5'd19, 32'h1234_5678);
    // bltu taken to 0x78, then ecall
    add_row(32'h0000_0070, 32'h0032_6463, 1'b0, 5'd0,  32'h0000_0000);
    add_row(32'h0000_0078, 32'h0000_0073, 1'b0, 5'd0,  32'h0000_0000);
  endtask

`endif

// ==== tb_rv_core.sv ====
//////////////////////////////
// slave answers only instruction reads below 0x100
//////////////////////////////
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  localparam int MEM_WORDS      = 64;
  localparam int RETIRE_TIMEOUT = 20;
  localparam int HALT_TIMEOUT   = 10;
  localparam int QUIET_CYCLES   = 40;

  logic     clk;
  logic     rst;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  word_t    wb_adr;
  logic     wb_ack;
  word_t    wb_dat_i;
  logic     halt;
  logic     retire_valid;
  word_t    retire_pc;
  reg_idx_t retire_rd;
  logic     retire_we;
  word_t    retire_data;

  word_t    mem [0:MEM_WORDS-1];
  word_t    exp_pc [$];
  logic     exp_we [$];
  reg_idx_t exp_rd [$];
  word_t    exp_data [$];
  int       errors;
  int       checks;
  integer   seed = 32'h9335b594;

  rv_core rv_core_i (
    .clk          (clk),
    .rst          (rst),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_ack       (wb_ack),
    .wb_dat_i     (wb_dat_i),
    .halt         (halt),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_we    (retire_we),
    .retire_data  (retire_data)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s is 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  // unused words read back as the inverted address
  function automatic word_t fill_word(input word_t addr);
    return ~addr;
  endfunction

  function automatic word_t read_mem(input word_t addr);
    if (addr[31:8] == 24'd0) begin
      return mem[addr[7:2]];
    end
    return fill_word(addr);
  endfunction

  task automatic add_row(input word_t addr, input word_t insn, input logic we,
                         input reg_idx_t rd, input word_t data);
    mem[addr[7:2]] = insn;
    exp_pc.push_back(addr);
    exp_we.push_back(we);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
  endtask

  `include "tb_rv_program.svh"

  // wishbone slave, 0 to 3 wait cycles per request
  initial begin : wb_slave
    int    wait_left;
    logic  busy;
    word_t held_adr;
    wb_ack    = 1'b0;
    wb_dat_i  = '0;
    busy      = 1'b0;
    wait_left = 0;
    held_adr  = '0;
    forever begin
      @(negedge clk);
      if (wb_ack) begin
        wb_ack = 1'b0;
        busy   = 1'b0;
      end else if (!rst && wb_cyc && wb_stb) begin
        if (!busy) begin
          busy      = 1'b1;
          held_adr  = wb_adr;
          wait_left = $random(seed) & 3;
        end
        check_value("wb_adr", wb_adr, held_adr);
        check_value("wb_we", 32'(wb_we), 32'd0);
        if (wait_left == 0) begin
          wb_ack   = 1'b1;
          wb_dat_i = read_mem(wb_adr);
        end else begin
          wait_left--;
        end
      end
    end
  end

  task automatic wait_retire(output bit seen);
    seen = 1'b0;
    for (int n = 0; n < RETIRE_TIMEOUT && !seen; n++) begin
      @(negedge clk);
      seen = retire_valid;
    end
  endtask

  // halt must rise and the bus must stay idle afterwards
  task automatic check_halt();
    bit seen;
    int stray;
    seen  = 1'b0;
    stray = 0;
    for (int n = 0; n < HALT_TIMEOUT && !seen; n++) begin
      @(negedge clk);
      seen = halt;
    end
    if (!seen) begin
      errors++;
      $display("halt did not rise after the ecall retired");
    end else begin
      for (int n = 0; n < QUIET_CYCLES; n++) begin
        @(negedge clk);
        if (wb_stb || wb_cyc || retire_valid) begin
          stray++;
        end
        check_value("halt", 32'(halt), 32'd1);
      end
      checks++;
      if (stray != 0) begin
        errors++;
        $display("bus or retire activity in %0d cycles after halt", stray);
      end
    end
  endtask

  initial begin : main
    bit seen;
    bit timed_out;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    rst       = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(32'(i) << 2);
    end
    load_program();
    repeat (3) @(negedge clk);
    rst = 1'b0;
    // idle state straight out of reset
    check_value("wb_cyc", 32'(wb_cyc), 32'd0);
    check_value("wb_stb", 32'(wb_stb), 32'd0);
    check_value("retire_valid", 32'(retire_valid), 32'd0);
    check_value("halt", 32'(halt), 32'd0);
    for (int i = 0; i < exp_pc.size(); i++) begin
      wait_retire(seen);
      if (!seen) begin
        errors++;
        timed_out = 1'b1;
        $display("no retire within %0d cycles for entry %0d at pc 0x%08h",
                 RETIRE_TIMEOUT, i, exp_pc[i]);
        break;
      end
      check_value("retire_pc", retire_pc, exp_pc[i]);
      check_value("retire_we", 32'(retire_we), 32'(exp_we[i]));
      if (exp_we[i]) begin
        check_value("retire_rd", 32'(retire_rd), 32'(exp_rd[i]));
        check_value("retire_data", retire_data, exp_data[i]);
      end
    end
    if (!timed_out) begin
      check_halt();
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_rv_core \
  -f filelist.f -o sim_rv_core \
  && ./obj_dir/sim_rv_core | tee sim.log \
  && grep -q "^Verification passed$" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
